/* src/eth_mac_pkg.sv */
// Shared definitions for the Ethernet MAC management block.
// Register map, field positions, MDIO frame constants and the bus structs.
// Imported by every RTL module of the design.

package eth_mac_pkg;

  // ============================================================
  // widths and identity
  // ============================================================
  localparam int REG_ADDR_W  = 12;
  localparam int REG_DATA_W  = 32;
  localparam int AXI_DATA_W  = 64;
  localparam int MDIO_ADDR_W = 5;
  localparam int MDIO_DATA_W = 16;

  localparam logic [15:0] MAC_ID = 16'h1234;

  // ============================================================
  // register word offsets
  // ============================================================
  localparam logic [4:0] REG_CTRL       = 5'd0;
  localparam logic [4:0] REG_SCRATCH    = 5'd3;
  localparam logic [4:0] REG_MDIO_CMD   = 5'd4;
  localparam logic [4:0] REG_MDIO_WDATA = 5'd5;
  localparam logic [4:0] REG_MDIO_RDATA = 5'd6;
  localparam logic [4:0] REG_MDIO_STAT  = 5'd7;

  // field positions
  localparam int CTRL_PHY_RST_BIT = 0;
  localparam int STAT_BUSY_BIT    = 0;
  localparam int STAT_INIT_BIT    = 4;
  localparam int CMD_OP_BIT       = 10;
  localparam int CMD_PHY_LSB      = 5;
  localparam int CMD_REG_LSB      = 0;

  // half-cycle counts of the MDIO frame
  localparam int MDIO_FRAME_LAST = 65;
  localparam int MDIO_TA_CNT     = 29;

  // register request from the AXI slave
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
  } reg_req_t;

  // MDIO command, op = 1 is a read
  typedef struct packed {
    logic                   op;
    logic [MDIO_ADDR_W-1:0] phy_addr;
    logic [MDIO_ADDR_W-1:0] reg_addr;
    logic [MDIO_DATA_W-1:0] wdata;
  } mdio_cmd_t;

endpackage

/* src/axi_lite_slave.sv */
// AXI4-Lite slave with a 64-bit data bus in front of the register block.
// Turns AXI transfers into one-cycle register read and write strobes.

`timescale 1ns/1ps

module axi_lite_slave import eth_mac_pkg::*; (
  input  logic                  s_axi_aclk,
  input  logic                  s_axi_aresetn,
  input  logic [REG_ADDR_W+1:0] s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  logic [AXI_DATA_W-1:0] s_axi_wdata_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  output logic [1:0]            s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  input  logic [REG_ADDR_W+1:0] s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output logic [AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic [1:0]            s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,
  input  logic [REG_DATA_W-1:0] rd_data_i,
  input  logic                  rd_done_i,
  output reg_req_t              req_o
);

  typedef enum logic [1:0] {WR_IDLE, WR_DATA_WAIT, WR_REQ, WR_RESP} wr_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_RESP} rd_state_t;

  wr_state_t             wr_state;
  rd_state_t             rd_state;
  logic [REG_ADDR_W-1:0] waddr_q;
  logic [REG_ADDR_W-1:0] raddr_q;
  logic [REG_DATA_W-1:0] wdata_q;
  logic [REG_DATA_W-1:0] rdata_q;
  logic                  wr_req;
  logic                  rd_req;

  // a pending write owns the shared address for its single cycle
  assign wr_req = (wr_state == WR_REQ);
  assign rd_req = (rd_state == RD_REQ) && !wr_req;

  assign req_o.wr    = wr_req;
  assign req_o.rd    = rd_req;
  assign req_o.addr  = wr_req ? waddr_q : raddr_q;
  assign req_o.wdata = wdata_q;

  assign s_axi_bresp_o = 2'b00;
  assign s_axi_rresp_o = 2'b00;
  assign s_axi_rdata_o = {rdata_q, rdata_q};

  // ============================================================
  // write channel
  // ============================================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      wr_state        <= WR_IDLE;
      waddr_q         <= '0;
      s_axi_awready_o <= 1'b1;
      s_axi_wready_o  <= 1'b1;
      s_axi_bvalid_o  <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (s_axi_awvalid_i) begin
            waddr_q         <= s_axi_awaddr_i[REG_ADDR_W+1:2];
            s_axi_awready_o <= 1'b0;
            if (s_axi_wvalid_i) begin
              s_axi_wready_o <= 1'b0;
              wr_state       <= WR_REQ;
            end else begin
              wr_state <= WR_DATA_WAIT;
            end
          end
        end
        WR_DATA_WAIT: begin
          if (s_axi_wvalid_i) begin
            s_axi_wready_o <= 1'b0;
            wr_state       <= WR_REQ;
          end
        end
        WR_REQ: begin
          s_axi_bvalid_o <= 1'b1;
          wr_state       <= WR_RESP;
        end
        default: begin
          if (s_axi_bready_i) begin
            s_axi_bvalid_o  <= 1'b0;
            s_axi_awready_o <= 1'b1;
            s_axi_wready_o  <= 1'b1;
            wr_state        <= WR_IDLE;
          end
        end
      endcase
    end
  end

  // lane pick, byte address bit 2 selects the upper word
  always_ff @(posedge s_axi_aclk) begin
    if (wr_state == WR_IDLE && s_axi_awvalid_i && s_axi_wvalid_i) begin
      wdata_q <= s_axi_awaddr_i[2] ? s_axi_wdata_i[63:32] : s_axi_wdata_i[31:0];
    end else if (wr_state == WR_DATA_WAIT && s_axi_wvalid_i) begin
      wdata_q <= waddr_q[0] ? s_axi_wdata_i[63:32] : s_axi_wdata_i[31:0];
    end
  end

  // ============================================================
  // read channel
  // ============================================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_state        <= RD_IDLE;
      raddr_q         <= '0;
      s_axi_arready_o <= 1'b1;
      s_axi_rvalid_o  <= 1'b0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (s_axi_arvalid_i) begin
            raddr_q         <= s_axi_araddr_i[REG_ADDR_W+1:2];
            s_axi_arready_o <= 1'b0;
            rd_state        <= RD_REQ;
          end
        end
        RD_REQ: begin
          if (rd_done_i) begin
            s_axi_rvalid_o <= 1'b1;
            rd_state       <= RD_RESP;
          end
        end
        default: begin
          if (s_axi_rready_i) begin
            s_axi_rvalid_o  <= 1'b0;
            s_axi_arready_o <= 1'b1;
            rd_state        <= RD_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (rd_state == RD_REQ && rd_done_i) begin
      rdata_q <= rd_data_i;
    end
  end

endmodule

/* src/mac_regs.sv */
// Register block of the MAC management side.
// Holds scratch and MDIO command registers, times the PHY reset pulse
// and hands MDIO start and init requests to the MDIO master.

`timescale 1ns/1ps

module mac_regs import eth_mac_pkg::*; #(
  parameter int PHY_RST_CYCLES = 31
) (
  input  logic                   s_axi_aclk,
  input  logic                   s_axi_aresetn,
  input  reg_req_t               req_i,
  input  logic                   mdio_busy_i,
  input  logic                   mdio_init_i,
  input  logic [MDIO_DATA_W-1:0] mdio_rdata_i,
  output logic [REG_DATA_W-1:0]  rdata_o,
  output logic                   rd_done_o,
  output logic                   phy_rst_n_o,
  output mdio_cmd_t              mdio_cmd_o,
  output logic                   mdio_start_o,
  output logic                   mdio_init_kick_o
);

  localparam int RST_CNT_W = $clog2(PHY_RST_CYCLES + 1);

  logic                  reg_sel;
  logic [4:0]            offset;
  logic                  wr_hit;
  logic [REG_DATA_W-1:0] scratch_q;
  mdio_cmd_t             cmd_q;
  logic [RST_CNT_W-1:0]  rst_cnt;
  logic [REG_DATA_W-1:0] rd_word;

  // only the lowest 32 words hold registers
  assign reg_sel = (req_i.addr[REG_ADDR_W-1:5] == '0);
  assign offset  = req_i.addr[4:0];
  assign wr_hit  = req_i.wr && reg_sel;

  assign mdio_cmd_o       = cmd_q;
  assign mdio_start_o     = wr_hit && (offset == REG_MDIO_STAT) && req_i.wdata[STAT_BUSY_BIT];
  assign mdio_init_kick_o = wr_hit && (offset == REG_MDIO_STAT) && req_i.wdata[STAT_INIT_BIT];

  // ============================================================
  // register writes
  // ============================================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      scratch_q      <= '0;
      cmd_q.op       <= 1'b0;
      cmd_q.phy_addr <= 5'd1;
      cmd_q.reg_addr <= '0;
      cmd_q.wdata    <= '0;
    end else if (wr_hit) begin
      case (offset)
        REG_SCRATCH: scratch_q <= req_i.wdata;
        REG_MDIO_CMD: begin
          cmd_q.op       <= req_i.wdata[CMD_OP_BIT];
          cmd_q.phy_addr <= req_i.wdata[CMD_PHY_LSB +: MDIO_ADDR_W];
          cmd_q.reg_addr <= req_i.wdata[CMD_REG_LSB +: MDIO_ADDR_W];
        end
        REG_MDIO_WDATA: cmd_q.wdata <= req_i.wdata[MDIO_DATA_W-1:0];
        default: ;
      endcase
    end
  end

  // ============================================================
  // read mux
  // ============================================================
  always_comb begin
    rd_word = '0;
    if (reg_sel) begin
      case (offset)
        REG_CTRL:       rd_word = {MAC_ID, 16'h0000};
        REG_SCRATCH:    rd_word = scratch_q;
        REG_MDIO_CMD: begin
          rd_word[CMD_OP_BIT]                     = cmd_q.op;
          rd_word[CMD_PHY_LSB +: MDIO_ADDR_W]     = cmd_q.phy_addr;
          rd_word[CMD_REG_LSB +: MDIO_ADDR_W]     = cmd_q.reg_addr;
        end
        REG_MDIO_WDATA: rd_word[MDIO_DATA_W-1:0] = cmd_q.wdata;
        REG_MDIO_RDATA: rd_word[MDIO_DATA_W-1:0] = mdio_rdata_i;
        REG_MDIO_STAT: begin
          rd_word[STAT_BUSY_BIT] = mdio_busy_i;
          rd_word[STAT_INIT_BIT] = mdio_init_i;
        end
        default: rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_done_o <= 1'b0;
    end else begin
      rd_done_o <= req_i.rd;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (req_i.rd) begin
      rdata_o <= rd_word;
    end
  end

  // ============================================================
  // phy reset pulse
  // ============================================================
  // counter loads on the strobe edge, pin goes low one edge later
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rst_cnt     <= '0;
      phy_rst_n_o <= 1'b1;
    end else begin
      if (wr_hit && (offset == REG_CTRL) && req_i.wdata[CTRL_PHY_RST_BIT]) begin
        rst_cnt <= RST_CNT_W'(PHY_RST_CYCLES);
      end else if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      phy_rst_n_o <= (rst_cnt == '0);
    end
  end

endmodule

/* src/mdio_master.sv */
// MDIO management master with MDC at half the system clock rate.
// Runs the post-reset MDC preamble and single clause-22 read or write
// frames from the command held in the register block.

`timescale 1ns/1ps

module mdio_master import eth_mac_pkg::*; #(
  parameter int MDIO_INIT_LAST = 125
) (
  input  logic                   s_axi_aclk,
  input  logic                   s_axi_aresetn,
  input  mdio_cmd_t              cmd_i,
  input  logic                   start_i,
  input  logic                   init_kick_i,
  input  logic                   phy_mdio_i,
  output logic                   busy_o,
  output logic                   init_o,
  output logic [MDIO_DATA_W-1:0] rdata_o,
  output logic                   phy_mdio_o,
  output logic                   phy_mdio_t_o,
  output logic                   phy_mdc_o
);

  localparam int CNT_W = $clog2(MDIO_INIT_LAST + 1);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-2:0] mdc_idx;
  mdio_cmd_t        cmd_q;
  logic             frame_end;

  // bit carried by MDC cycle idx of the frame
  function automatic logic frame_bit(input mdio_cmd_t c, input int idx);
    logic b;
    b = 1'b1;
    if (idx == 0) b = 1'b0;
    else if (idx == 1) b = 1'b1;
    else if (idx == 2) b = c.op;
    else if (idx == 3) b = !c.op;
    else if (idx <= 8) b = c.phy_addr[8 - idx];
    else if (idx <= 13) b = c.reg_addr[13 - idx];
    else if (idx == 14) b = 1'b1;
    else if (idx == 15) b = 1'b0;
    else if (idx <= 31) b = c.op ? 1'b0 : c.wdata[31 - idx];
    return b;
  endfunction

  assign mdc_idx   = cnt[CNT_W-1:1];
  assign frame_end = busy_o && (cnt == CNT_W'(MDIO_FRAME_LAST));
  assign phy_mdc_o = cnt[0];

  // line released while init is pending and after a read turnaround
  assign phy_mdio_t_o = init_o || (busy_o && cmd_q.op && (cnt > CNT_W'(MDIO_TA_CNT)));

  // ============================================================
  // half-cycle counter, init and busy
  // ============================================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      cnt    <= '0;
      init_o <= 1'b1;
      busy_o <= 1'b0;
    end else begin
      if (init_o && (cnt == CNT_W'(MDIO_INIT_LAST))) begin
        init_o <= 1'b0;
        cnt    <= '0;
      end else if (init_o && init_kick_i && (cnt == '0) && !busy_o) begin
        cnt <= 1;
      end else if (init_o && (cnt != '0)) begin
        cnt <= cnt + 1'b1;
      end else if (frame_end) begin
        cnt <= '0;
      end else if (busy_o) begin
        cnt <= cnt + 1'b1;
      end

      if (start_i && !busy_o) begin
        busy_o <= 1'b1;
      end else if (frame_end) begin
        busy_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (start_i && !busy_o) begin
      cmd_q <= cmd_i;
    end
  end

  // ============================================================
  // serial out and read capture on MDC falling edges
  // ============================================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      phy_mdio_o <= 1'b1;
      rdata_o    <= '0;
    end else if (busy_o && cnt[0]) begin
      phy_mdio_o <= frame_bit(cmd_q, int'(mdc_idx));
      if (cmd_q.op && (mdc_idx >= 16) && (mdc_idx <= 31)) begin
        rdata_o <= {rdata_o[MDIO_DATA_W-2:0], phy_mdio_i};
      end
    end
  end

endmodule

/* src/eth_mac_mgmt_top.sv */
// Top level of the Ethernet MAC management side.
// AXI4-Lite register access, PHY reset pulse and MDIO management pins.

`timescale 1ns/1ps

module eth_mac_mgmt_top import eth_mac_pkg::*; #(
  parameter int PHY_RST_CYCLES = 31,
  parameter int MDIO_INIT_LAST = 125
) (
  input  logic                  s_axi_aclk,
  input  logic                  s_axi_aresetn,
  input  logic [REG_ADDR_W+1:0] s_axi_awaddr_i,
  input  logic                  s_axi_awvalid_i,
  output logic                  s_axi_awready_o,
  input  logic [AXI_DATA_W-1:0] s_axi_wdata_i,
  input  logic                  s_axi_wvalid_i,
  output logic                  s_axi_wready_o,
  output logic [1:0]            s_axi_bresp_o,
  output logic                  s_axi_bvalid_o,
  input  logic                  s_axi_bready_i,
  input  logic [REG_ADDR_W+1:0] s_axi_araddr_i,
  input  logic                  s_axi_arvalid_i,
  output logic                  s_axi_arready_o,
  output logic [AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic [1:0]            s_axi_rresp_o,
  output logic                  s_axi_rvalid_o,
  input  logic                  s_axi_rready_i,
  output logic                  phy_rst_n_o,
  input  logic                  phy_mdio_i,
  output logic                  phy_mdio_o,
  output logic                  phy_mdio_t_o,
  output logic                  phy_mdc_o
);

  reg_req_t               reg_req;
  logic [REG_DATA_W-1:0]  reg_rdata;
  logic                   reg_rd_done;
  mdio_cmd_t              mdio_cmd;
  logic                   mdio_start;
  logic                   mdio_init_kick;
  logic                   mdio_busy;
  logic                   mdio_init;
  logic [MDIO_DATA_W-1:0] mdio_rdata;

  axi_lite_slave axi_lite_slave_inst (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .rd_data_i       (reg_rdata),
    .rd_done_i       (reg_rd_done),
    .req_o           (reg_req)
  );

  mac_regs #(
    .PHY_RST_CYCLES (PHY_RST_CYCLES)
  ) mac_regs_inst (
    .s_axi_aclk       (s_axi_aclk),
    .s_axi_aresetn    (s_axi_aresetn),
    .req_i            (reg_req),
    .mdio_busy_i      (mdio_busy),
    .mdio_init_i      (mdio_init),
    .mdio_rdata_i     (mdio_rdata),
    .rdata_o          (reg_rdata),
    .rd_done_o        (reg_rd_done),
    .phy_rst_n_o      (phy_rst_n_o),
    .mdio_cmd_o       (mdio_cmd),
    .mdio_start_o     (mdio_start),
    .mdio_init_kick_o (mdio_init_kick)
  );

  mdio_master #(
    .MDIO_INIT_LAST (MDIO_INIT_LAST)
  ) mdio_master_inst (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .cmd_i         (mdio_cmd),
    .start_i       (mdio_start),
    .init_kick_i   (mdio_init_kick),
    .phy_mdio_i    (phy_mdio_i),
    .busy_o        (mdio_busy),
    .init_o        (mdio_init),
    .rdata_o       (mdio_rdata),
    .phy_mdio_o    (phy_mdio_o),
    .phy_mdio_t_o  (phy_mdio_t_o),
    .phy_mdc_o     (phy_mdc_o)
  );

endmodule

/* sim/tb_eth_mac_mgmt.sv */
// Directed testbench for the Ethernet MAC management top level.
// Drives AXI4-Lite transfers, models a PHY on the MDIO pins and checks
// register access, handshakes, the PHY reset pulse and MDIO frames.

`timescale 1ns/1ps

module tb_eth_mac_mgmt import eth_mac_pkg::*; ();

  localparam int PHY_RST_CYCLES = 31;
  localparam int MDIO_INIT_LAST = 125;
  localparam int WAIT_LIMIT     = 400;

  logic                  s_axi_aclk;
  logic                  s_axi_aresetn;
  logic [REG_ADDR_W+1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [REG_ADDR_W+1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  phy_rst_n;
  logic                  phy_mdio_i;
  logic                  phy_mdio_o;
  logic                  phy_mdio_t;
  logic                  phy_mdc;

  int     mismatch_cnt;
  int     fail_cnt;
  integer seed;

  eth_mac_mgmt_top #(
    .PHY_RST_CYCLES (PHY_RST_CYCLES),
    .MDIO_INIT_LAST (MDIO_INIT_LAST)
  ) eth_mac_mgmt_top_inst (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .phy_rst_n_o     (phy_rst_n),
    .phy_mdio_i      (phy_mdio_i),
    .phy_mdio_o      (phy_mdio_o),
    .phy_mdio_t_o    (phy_mdio_t),
    .phy_mdc_o       (phy_mdc)
  );

  initial s_axi_aclk = 1'b0;
  always #50 s_axi_aclk = ~s_axi_aclk;

  // ============================================================
  // compare and report helpers
  // ============================================================
  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic compare_mdio_cmd(input mdio_cmd_t got, input mdio_cmd_t exp);
    if (got !== exp) begin
      $display("Mismatch mdio frame: got 0x%07h expected 0x%07h", got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    fail_cnt++;
  endtask

  task automatic check_cycles(input string what, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("%s took %0d cycles instead of %0d", what, got, exp));
    end
  endtask

  function automatic logic [13:0] byte_addr(input logic [4:0] off);
    return {7'd0, off, 2'b00};
  endfunction

  // put the word in the lane picked by byte address bit 2
  function automatic logic [63:0] place_lane(input logic [13:0] addr, input logic [31:0] w,
                                             input logic [31:0] other);
    return addr[2] ? {w, other} : {other, w};
  endfunction

  // ============================================================
  // AXI driver tasks
  // ============================================================
  task automatic axi_write(input logic [13:0] addr, input logic [63:0] data,
                           input bit late, input int stall);
    int n;
    @(posedge s_axi_aclk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= !late;
    bready  <= (stall == 0);
    @(posedge s_axi_aclk);
    awvalid <= 1'b0;
    if (late) begin
      wvalid <= 1'b1;
      @(posedge s_axi_aclk);
    end
    wvalid <= 1'b0;
    n = 0;
    @(negedge s_axi_aclk);
    while (!bvalid && n < WAIT_LIMIT) begin
      n++;
      @(negedge s_axi_aclk);
    end
    if (!bvalid) begin
      report_failure("write response never arrived");
    end else begin
      check_cycles("write response", n, 1);
      compare_word("bresp", {30'd0, bresp}, 32'd0);
    end
    repeat (stall) begin
      compare_bit("bvalid", bvalid, 1'b1);
      compare_bit("awready", awready, 1'b0);
      compare_bit("wready", wready, 1'b0);
      @(negedge s_axi_aclk);
    end
    @(posedge s_axi_aclk);
    bready <= 1'b1;
    @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    compare_bit("bvalid", bvalid, 1'b0);
    compare_bit("awready", awready, 1'b1);
    compare_bit("wready", wready, 1'b1);
  endtask

  task automatic axi_read(input logic [13:0] addr, input int stall, output logic [31:0] data);
    int n;
    @(posedge s_axi_aclk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= (stall == 0);
    @(posedge s_axi_aclk);
    arvalid <= 1'b0;
    n = 0;
    data = '0;
    @(negedge s_axi_aclk);
    while (!rvalid && n < WAIT_LIMIT) begin
      n++;
      @(negedge s_axi_aclk);
    end
    if (!rvalid) begin
      report_failure("read data never arrived");
    end else begin
      check_cycles("read response", n, 2);
      data = rdata[31:0];
      compare_word("rdata upper half", rdata[63:32], rdata[31:0]);
      compare_word("rresp", {30'd0, rresp}, 32'd0);
    end
    repeat (stall) begin
      compare_bit("rvalid", rvalid, 1'b1);
      compare_bit("arready", arready, 1'b0);
      compare_word("rdata held", rdata[31:0], data);
      @(negedge s_axi_aclk);
    end
    @(posedge s_axi_aclk);
    rready <= 1'b1;
    @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    compare_bit("rvalid", rvalid, 1'b0);
    compare_bit("arready", arready, 1'b1);
  endtask

  task automatic wait_mdio_idle();
    logic [31:0] stat;
    int          n;
    n = 0;
    axi_read(byte_addr(REG_MDIO_STAT), 0, stat);
    while (stat[STAT_BUSY_BIT] && n < 50) begin
      n++;
      axi_read(byte_addr(REG_MDIO_STAT), 0, stat);
    end
    if (stat[STAT_BUSY_BIT]) begin
      report_failure("MDIO busy never cleared");
    end
  endtask

  // ============================================================
  // PHY model
  // ============================================================
  task automatic wait_mdc_level(input logic level, output bit ok);
    int n;
    n = 0;
    @(negedge s_axi_aclk);
    while (phy_mdc !== level && n < WAIT_LIMIT) begin
      n++;
      @(negedge s_axi_aclk);
    end
    ok = (phy_mdc === level);
  endtask

  // first MDC rise of a frame carries no bit, the next 32 carry the frame
  task automatic phy_model_serve(input logic [15:0] rd_val, input bit is_read,
                                 output mdio_cmd_t got);
    logic [31:0] bits;
    bit          ok;
    int          r;
    bits = '0;
    for (r = 0; r <= 32; r++) begin
      wait_mdc_level(1'b1, ok);
      if (!ok) begin
        report_failure("MDC stopped rising during a frame");
        break;
      end
      if (r > 0) bits[32 - r] = phy_mdio_o;
      // rise r of the frame sits at half-cycle count 2r+1
      compare_bit("phy_mdio_t", phy_mdio_t, is_read && (2 * r + 1 > MDIO_TA_CNT));
      // MDC falls on the next clock edge
      @(posedge s_axi_aclk);
      if (is_read && r >= 15 && r <= 30) phy_mdio_i <= rd_val[30 - r];
      else phy_mdio_i <= 1'b1;
      wait_mdc_level(1'b0, ok);
      if (!ok) begin
        report_failure("MDC stopped falling during a frame");
        break;
      end
    end
    compare_word("frame start bits", {30'd0, bits[31:30]}, 32'h1);
    compare_bit("frame op complement", bits[28], !is_read);
    compare_word("frame turnaround bits", {30'd0, bits[17:16]}, 32'h2);
    got = {bits[29], bits[27:23], bits[22:18], bits[15:0]};
  endtask

  task automatic measure_rst_pulse();
    int n;
    n = 0;
    @(negedge s_axi_aclk);
    while (phy_rst_n && n < WAIT_LIMIT) begin
      n++;
      @(negedge s_axi_aclk);
    end
    n = 0;
    while (!phy_rst_n && n < WAIT_LIMIT) begin
      n++;
      @(negedge s_axi_aclk);
    end
    check_cycles("phy reset pulse", n, PHY_RST_CYCLES);
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic register_access();
    logic [31:0] val;
    logic [31:0] rnd;
    logic [31:0] other;
    logic [13:0] a;
    axi_read(byte_addr(REG_CTRL), 0, val);
    compare_word("ctrl", val, {MAC_ID, 16'h0000});
    repeat (2) begin
      rnd   = $random(seed);
      other = $random(seed);
      a     = byte_addr(REG_SCRATCH);
      axi_write(a, place_lane(a, rnd, other), 1'b0, 0);
      axi_read(a, 0, val);
      compare_word("scratch", val, rnd);
    end
    // command register sits in the lower lane
    rnd   = $random(seed);
    other = $random(seed);
    a     = byte_addr(REG_MDIO_CMD);
    axi_write(a, place_lane(a, rnd, other), 1'b0, 0);
    axi_read(a, 0, val);
    compare_word("mdio cmd", val, rnd & 32'h0000_07ff);
    a = byte_addr(5'd2);
    axi_write(a, {$random(seed), $random(seed)}, 1'b0, 0);
    axi_read(a, 0, val);
    compare_word("unused offset 2", val, 32'h0);
    axi_read(byte_addr(5'd1), 0, val);
    compare_word("unused offset 1", val, 32'h0);
    axi_read(byte_addr(5'd8), 0, val);
    compare_word("unused offset 8", val, 32'h0);
    axi_read(14'h0080, 0, val);
    compare_word("word 0x20", val, 32'h0);
  endtask

  task automatic handshake_backpressure();
    logic [31:0] val;
    logic [31:0] rnd;
    logic [13:0] a;
    rnd = $random(seed);
    a   = byte_addr(REG_SCRATCH);
    axi_write(a, place_lane(a, rnd, 32'hdead_beef), 1'b1, 10);
    axi_read(a, 10, val);
    compare_word("scratch after late data", val, rnd);
  endtask

  task automatic phy_reset_pulse();
    logic [13:0] a;
    a = byte_addr(REG_CTRL);
    fork
      axi_write(a, place_lane(a, 32'h1, 32'h0), 1'b0, 0);
      measure_rst_pulse();
    join
    compare_bit("phy_rst_n", phy_rst_n, 1'b1);
  endtask

  task automatic mdio_init_sequence();
    logic [31:0] val;
    logic [13:0] a;
    int          n;
    a = byte_addr(REG_MDIO_STAT);
    axi_read(a, 0, val);
    compare_word("mdio stat", val, 32'h10);
    compare_bit("phy_mdio_t", phy_mdio_t, 1'b1);
    axi_write(a, place_lane(a, 32'h10, 32'h0), 1'b0, 0);
    n = 0;
    while (!phy_mdc && n < WAIT_LIMIT) begin
      n++;
      @(negedge s_axi_aclk);
    end
    if (!phy_mdc) report_failure("MDC never toggled after the init kick");
    n = 0;
    while (phy_mdio_t && n < WAIT_LIMIT) begin
      n++;
      @(negedge s_axi_aclk);
    end
    if (phy_mdio_t) report_failure("init never finished");
    axi_read(a, 0, val);
    compare_word("mdio stat", val, 32'h0);
  endtask

  task automatic mdio_frame_transfer(input bit is_read);
    mdio_cmd_t   exp;
    mdio_cmd_t   got;
    logic [31:0] rnd;
    logic [31:0] val;
    logic [15:0] rd_val;
    logic [13:0] a;
    rnd          = $random(seed);
    exp.op       = is_read;
    exp.phy_addr = rnd[4:0];
    exp.reg_addr = rnd[9:5];
    exp.wdata    = is_read ? 16'h0 : rnd[31:16];
    rd_val       = 16'($random(seed));
    a = byte_addr(REG_MDIO_CMD);
    axi_write(a, place_lane(a, {21'd0, exp.op, exp.phy_addr, exp.reg_addr}, 32'h0), 1'b0, 0);
    a = byte_addr(REG_MDIO_WDATA);
    axi_write(a, place_lane(a, {16'h0, rnd[31:16]}, 32'h0), 1'b0, 0);
    a = byte_addr(REG_MDIO_STAT);
    fork
      axi_write(a, place_lane(a, 32'h1, 32'h0), 1'b0, 0);
      phy_model_serve(rd_val, is_read, got);
    join
    compare_mdio_cmd(got, exp);
    wait_mdio_idle();
    if (is_read) begin
      axi_read(byte_addr(REG_MDIO_RDATA), 0, val);
      compare_word("mdio rdata", val, {16'h0, rd_val});
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    mismatch_cnt  = 0;
    fail_cnt      = 0;
    seed          = 23;
    s_axi_aresetn = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wvalid        = 1'b0;
    bready        = 1'b1;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b1;
    phy_mdio_i    = 1'b1;
    repeat (16) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;
    @(negedge s_axi_aclk);
    compare_bit("awready", awready, 1'b1);
    compare_bit("wready", wready, 1'b1);
    compare_bit("arready", arready, 1'b1);
    compare_bit("bvalid", bvalid, 1'b0);
    compare_bit("rvalid", rvalid, 1'b0);
    compare_bit("phy_rst_n", phy_rst_n, 1'b1);
    compare_bit("phy_mdio_o", phy_mdio_o, 1'b1);
    compare_bit("phy_mdio_t", phy_mdio_t, 1'b1);
    compare_bit("phy_mdc", phy_mdc, 1'b0);

    register_access();
    handshake_backpressure();
    phy_reset_pulse();
    mdio_init_sequence();
    mdio_frame_transfer(1'b0);
    mdio_frame_transfer(1'b1);

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
src/eth_mac_pkg.sv
src/axi_lite_slave.sv
src/mac_regs.sv
src/mdio_master.sv
src/eth_mac_mgmt_top.sv
sim/tb_eth_mac_mgmt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_eth_mac_mgmt -f src.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q ">>> PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
